/* branch_macros.svh */
// width and depth macros for the branch cluster, include ahead of any code that sizes a bus
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// data and address width, rv32
`define XLEN 32

// rob entry tag, also names the producer of a pending operand
`define ROB_TAG_W 4

// branch reservation station entries, 2 or more
`define BRS_DEPTH 4

`endif

/* rv_isa_pkg.sv */
// instruction-set side encodings for branch execution, referenced as rv_isa_pkg::name
package rv_isa_pkg;

	// funct3 of B_TYPE
	// bit 0 set means the sense of the compare is inverted
	// bits 2:1 pick eq, signed lt or unsigned lt
	typedef enum logic [2:0] {
		BEQ  = 3'b000,	// v1 == v2
		BNE  = 3'b001,	// !(v1 == v2)
		BLT  = 3'b100,	// signed v1 < v2
		BGE  = 3'b101,	// !(signed v1 < v2)
		BLTU = 3'b110,	// unsigned v1 < v2
		BGEU = 3'b111	// !(unsigned v1 < v2)
	} branch_funct3_e;

	// what the branch unit does with the operands
	// conditional branch compares, jalr adds
	// jal never reaches this unit
	typedef enum logic {
		KIND_BRANCH = 1'b0,	// B_TYPE, target precomputed at decode
		KIND_JALR   = 1'b1	// target is rs1 + imm
	} branch_kind_e;

endpackage

/* tomasulo_pkg.sv */
// machine-side types of the out-of-order core, shared by the branch station, unit and bench
`include "branch_macros.svh"

package tomasulo_pkg;

	// tag reading of an operand word
	typedef struct packed {
		logic [`XLEN-`ROB_TAG_W-1:0] upper;	// don't care while waiting
		logic [`ROB_TAG_W-1:0]       tag;	// producer rob entry
	} tag_word_t;

	// one operand word, either the value itself or the producer tag
	typedef union packed {
		logic [`XLEN-1:0] value;
		tag_word_t        tag_word;
	} operand_u;

	// ready selects the reading of data
	typedef struct packed {
		logic     ready;	// 1: data.value valid, 0: data.tag_word valid
		operand_u data;
	} operand_t;

	// what dispatch hands to the branch station
	typedef struct packed {
		logic [`ROB_TAG_W-1:0]      rob_tag;
		rv_isa_pkg::branch_kind_e   kind;
		rv_isa_pkg::branch_funct3_e funct3;
		operand_t                   v1;	// rs1
		operand_t                   v2;	// rs2, or the immediate for jalr (always ready)
		logic [`XLEN-1:0]           pc_plus_four;
		logic [`XLEN-1:0]           pc_plus_immediate;
		logic [`XLEN-1:0]           predicted_next_instruction;
	} branch_issue_t;

	// common data bus, one broadcast per cycle
	typedef struct packed {
		logic                  valid;
		logic [`ROB_TAG_W-1:0] tag;	// producing rob entry
		logic [`XLEN-1:0]      value;
	} cdb_t;

	// resolved branch towards the rob
	typedef struct packed {
		logic [`ROB_TAG_W-1:0] rob_tag;
		logic [`XLEN-1:0]      next_instruction;
		logic                  redirect_mispredicted;	// fetch must restart at next_instruction
	} branch_result_t;

endpackage

/* branch_functional_unit.sv */
// combinational branch resolution, compares or adds the operands and flags a wrong prediction
`include "branch_macros.svh"

module branch_functional_unit (
	input  logic [`XLEN-1:0]         v1,	// rs1
	input  logic [`XLEN-1:0]         v2,	// rs2, or imm for jalr
	input  logic [`XLEN-1:0]         pc_plus_four,
	input  logic [`XLEN-1:0]         pc_plus_immediate,
	input  logic [`XLEN-1:0]         predicted_next_instruction,
	input  rv_isa_pkg::branch_funct3_e funct3,
	input  rv_isa_pkg::branch_kind_e   kind,
	output logic [`XLEN-1:0]         next_instruction,
	output logic                     redirect_mispredicted
);

	logic             v1_eq_v2;
	logic             v1_lt_v2;	// signed
	logic             v1_ltu_v2;	// unsigned
	logic             branch_comparison;
	logic             branch_taken;
	logic [`XLEN-1:0] branch_target;
	logic [`XLEN-1:0] jalr_target;

	// jalr target, bit 0 left as is
	assign jalr_target = v1 + v2;

	// all three compares in parallel
	assign v1_eq_v2  = (v1 == v2);
	assign v1_lt_v2  = ($signed(v1) < $signed(v2));
	assign v1_ltu_v2 = (v1 < v2);

	always_comb begin
		case (funct3)
			rv_isa_pkg::BEQ,
			rv_isa_pkg::BNE:  branch_comparison = v1_eq_v2;
			rv_isa_pkg::BLT,
			rv_isa_pkg::BGE:  branch_comparison = v1_lt_v2;
			rv_isa_pkg::BLTU,
			rv_isa_pkg::BGEU: branch_comparison = v1_ltu_v2;
			default:          branch_comparison = 1'b0;	// 010/011 not a branch, never issued
		endcase
	end

	// odd funct3 = negated compare
	assign branch_taken  = branch_comparison ^ funct3[0];
	assign branch_target = branch_taken ? pc_plus_immediate : pc_plus_four;

	// kind always names one of the two paths
	always_comb begin
		if (kind == rv_isa_pkg::KIND_JALR) begin
			next_instruction = jalr_target;
		end else begin
			next_instruction = branch_target;
		end
	end

	// any difference from the fetch guess means redirect
	assign redirect_mispredicted = (next_instruction != predicted_next_instruction);

endmodule

/* branch_reservation_station.sv */
// branch reservation station, waits for operands on the cdb and fires the oldest-index ready entry
`include "branch_macros.svh"

module branch_reservation_station (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        flush,	// one-cycle, empties the station
	input  logic                        issue,	// only while full is low
	input  tomasulo_pkg::branch_issue_t issue_packet,
	input  tomasulo_pkg::cdb_t          cdb,
	output logic                        full,
	output tomasulo_pkg::branch_issue_t fire_packet,	// operands resolved when fire
	output logic                        fire,
	input  logic [`XLEN-1:0]            fu_next_instruction,
	input  logic                        fu_mispredicted,
	output logic                        result_valid,
	output tomasulo_pkg::branch_result_t result
);

	localparam int IDX_W = $clog2(`BRS_DEPTH);

	logic [`BRS_DEPTH-1:0]       valid;
	logic [`BRS_DEPTH-1:0]       ready;	// valid and both operands present
	tomasulo_pkg::branch_issue_t entries [`BRS_DEPTH];
	logic [IDX_W-1:0]            free_idx;
	logic [IDX_W-1:0]            fire_idx;
	logic                        do_issue;

	// snoop the cdb for one waiting operand
	function automatic tomasulo_pkg::operand_t capture(
		input tomasulo_pkg::operand_t op,
		input tomasulo_pkg::cdb_t     bus
	);
		tomasulo_pkg::operand_t res;
		res = op;
		if (!op.ready && bus.valid && (op.data.tag_word.tag == bus.tag)) begin
			res.ready      = 1'b1;
			res.data.value = bus.value;
		end
		return res;
	endfunction

	assign full     = &valid;
	assign do_issue = issue && !full;

	always_comb begin
		for (int i = 0; i < `BRS_DEPTH; i++) begin
			ready[i] = valid[i] && entries[i].v1.ready && entries[i].v2.ready;
		end
	end

	// lowest free slot, scan from the top so index 0 wins
	always_comb begin
		free_idx = '0;
		for (int i = `BRS_DEPTH - 1; i >= 0; i--) begin
			if (!valid[i]) free_idx = IDX_W'(i);
		end
	end

	// lowest ready slot
	always_comb begin
		fire_idx = '0;
		for (int i = `BRS_DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) fire_idx = IDX_W'(i);
		end
	end

	assign fire        = |ready;
	assign fire_packet = entries[fire_idx];	// only meaningful with fire

	// occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (flush) begin
			valid <= '0;	// also drops a same-edge issue
		end else begin
			if (fire) valid[fire_idx] <= 1'b0;	// freed as it leaves
			if (do_issue) valid[free_idx] <= 1'b1;	// free slot never equals fire slot
		end
	end

	// entry payload, cdb capture on every edge
	always_ff @(posedge clk) begin
		for (int i = 0; i < `BRS_DEPTH; i++) begin
			entries[i].v1 <= capture(entries[i].v1, cdb);
			entries[i].v2 <= capture(entries[i].v2, cdb);
		end
		if (do_issue) begin
			entries[free_idx]    <= issue_packet;
			entries[free_idx].v1 <= capture(issue_packet.v1, cdb);	// same-cycle broadcast
			entries[free_idx].v2 <= capture(issue_packet.v2, cdb);
		end
	end

	// result strobe, flush kills the one being registered
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= fire && !flush;
		end
	end

	always_ff @(posedge clk) begin
		result.rob_tag               <= fire_packet.rob_tag;
		result.next_instruction      <= fu_next_instruction;
		result.redirect_mispredicted <= fu_mispredicted;
	end

endmodule

/* branch_unit_top.sv */
// branch execution cluster top, reservation station feeding the combinational branch unit
`include "branch_macros.svh"

module branch_unit_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         flush,
	input  logic                         issue,
	input  tomasulo_pkg::branch_issue_t  issue_packet,
	input  tomasulo_pkg::cdb_t           cdb,
	output logic                         full,
	output logic                         result_valid,
	output tomasulo_pkg::branch_result_t result
);

	tomasulo_pkg::branch_issue_t fire_packet;	// selected entry, operands resolved
	logic                        fire;
	logic [`XLEN-1:0]            fu_next_instruction;
	logic                        fu_mispredicted;

	branch_reservation_station brs0 (
		.clk                 (clk),
		.arst_n              (arst_n),
		.flush               (flush),
		.issue               (issue),
		.issue_packet        (issue_packet),
		.cdb                 (cdb),
		.full                (full),
		.fire_packet         (fire_packet),
		.fire                (fire),
		.fu_next_instruction (fu_next_instruction),
		.fu_mispredicted     (fu_mispredicted),
		.result_valid        (result_valid),
		.result              (result)
	);

	// unit is purely combinational, its answer only counts while fire is high
	branch_functional_unit bfu0 (
		.v1                         (fire ? fire_packet.v1.data.value : '0),
		.v2                         (fire ? fire_packet.v2.data.value : '0),
		.pc_plus_four               (fire_packet.pc_plus_four),
		.pc_plus_immediate          (fire_packet.pc_plus_immediate),
		.predicted_next_instruction (fire_packet.predicted_next_instruction),
		.funct3                     (fire_packet.funct3),
		.kind                       (fire_packet.kind),
		.next_instruction           (fu_next_instruction),
		.redirect_mispredicted      (fu_mispredicted)
	);

endmodule

/* branch_unit_props.sv */
// concurrent checks on the branch station, bound into every branch_reservation_station
module branch_unit_props (
	input logic                        clk,
	input logic                        arst_n,
	input logic                        flush,
	input logic                        issue,
	input logic                        full,
	input logic                        fire,
	input logic                        result_valid,
	input tomasulo_pkg::branch_issue_t fire_packet
);
	timeunit 1ns;
	timeprecision 100ps;

	// dispatch must hold off while full
	issue_not_full: assert property (@(posedge clk) disable iff (!arst_n) issue |-> !full)
		else $error("issue strobe while station full");

	// flush kills the result being registered
	flush_kills_result: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> !result_valid)
		else $error("result_valid high in the cycle after flush");

	fire_operands_ready: assert property (@(posedge clk) disable iff (!arst_n)
		fire |-> (fire_packet.v1.ready && fire_packet.v2.ready))
		else $error("entry fired with an operand still waiting");	// tag word would leak

endmodule

bind branch_reservation_station branch_unit_props props0 (.*);

/* branch_unit_tb.sv */
// testbench for the branch cluster, runs a stimulus table through branch_unit_top and checks results
`include "branch_macros.svh"

module branch_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ROWS = 16;	// 14 fixed + 2 random
	localparam int WATCHDOG_CYCLES = (N_ROWS + 6) * 40 + 16;	// table, flush phase, reset

	typedef struct packed {
		rv_isa_pkg::branch_kind_e   kind;
		rv_isa_pkg::branch_funct3_e funct3;
		logic [`XLEN-1:0]           v1;
		logic [`XLEN-1:0]           v2;
		logic [`XLEN-1:0]           pc;
		logic [`XLEN-1:0]           imm;
		logic [`XLEN-1:0]           pred;
		logic [1:0]                 late;	// bit0 v1 on cdb, bit1 v2 on cdb
		logic [3:0]                 delay;	// cycles after issue edge
	} test_row_t;

	logic                         clk = 1'b0;
	logic                         arst_n;
	logic                         flush;
	logic                         issue;
	tomasulo_pkg::branch_issue_t  issue_packet;
	tomasulo_pkg::cdb_t           cdb;
	logic                         full;
	logic                         result_valid;
	tomasulo_pkg::branch_result_t result;

	test_row_t        rows [N_ROWS];
	logic [`XLEN-1:0] exp_next [16];	// indexed by rob tag
	logic             exp_mis [16];
	logic             pending [16];
	logic             slot_v [4096];	// cdb schedule by cycle
	logic [3:0]       slot_tag [4096];
	logic [`XLEN-1:0] slot_val [4096];
	int               cyc = 0;
	int               outstanding = 0;
	int               checked = 0;
	int               errors = 0;
	int               seed = 32'h9d438700;
	logic             saw_full = 1'b0;
	rv_isa_pkg::branch_funct3_e f3_list [6] = '{rv_isa_pkg::BEQ, rv_isa_pkg::BNE,
		rv_isa_pkg::BLT, rv_isa_pkg::BGE, rv_isa_pkg::BLTU, rv_isa_pkg::BGEU};

	branch_unit_top dut0 (.*);

	always #4 clk = ~clk;	// 8 ns period

	// cdb driver, slot n lands at edge n+1
	always @(posedge clk) begin
		cyc = cyc + 1;
		cdb <= '{valid: slot_v[cyc], tag: slot_tag[cyc], value: slot_val[cyc]};
	end

	// next pc straight from the isa rules
	function automatic logic [`XLEN-1:0] expected_next(input test_row_t r);
		logic taken;
		case (r.funct3)
			rv_isa_pkg::BEQ:  taken = (r.v1 == r.v2);
			rv_isa_pkg::BNE:  taken = (r.v1 != r.v2);
			rv_isa_pkg::BLT:  taken = ($signed(r.v1) < $signed(r.v2));
			rv_isa_pkg::BGE:  taken = ($signed(r.v1) >= $signed(r.v2));
			rv_isa_pkg::BLTU: taken = (r.v1 < r.v2);
			default:          taken = (r.v1 >= r.v2);	// bgeu
		endcase
		if (r.kind == rv_isa_pkg::KIND_JALR) return r.v1 + r.v2;	// no bit-0 clear
		return taken ? r.pc + r.imm : r.pc + 32'd4;
	endfunction

	task automatic schedule(input logic [3:0] tag, input logic [`XLEN-1:0] val, input int at);
		while (slot_v[at]) at++;	// one broadcast per cycle
		slot_v[at] = 1'b1;
		slot_tag[at] = tag;
		slot_val[at] = val;
	endtask

	// drives one packet, broadcast=0 leaves late operands waiting forever
	task automatic issue_row(input int tag, input test_row_t r, input bit broadcast);
		tomasulo_pkg::branch_issue_t pkt;
		logic [3:0] p1;
		logic [3:0] p2;
		p1 = {tag[2:0], 1'b0};	// producer tags unique among waiting rows
		p2 = {tag[2:0], 1'b1};
		pkt = '0;
		pkt.rob_tag = tag[3:0];
		pkt.kind = r.kind;
		pkt.funct3 = r.funct3;
		pkt.v1.ready = !r.late[0];
		pkt.v1.data.value = r.late[0] ? {28'h0, p1} : r.v1;
		pkt.v2.ready = !r.late[1];
		pkt.v2.data.value = r.late[1] ? {28'h0, p2} : r.v2;
		pkt.pc_plus_four = r.pc + 32'd4;
		pkt.pc_plus_immediate = r.pc + r.imm;
		pkt.predicted_next_instruction = r.pred;
		exp_next[tag] = expected_next(r);
		exp_mis[tag] = (exp_next[tag] != r.pred);
		pending[tag] = 1'b1;
		outstanding++;
		@(negedge clk);
		while (full) @(negedge clk);
		if (broadcast && r.late[0]) schedule(p1, r.v1, cyc + 1 + r.delay);
		if (broadcast && r.late[1]) schedule(p2, r.v2, cyc + 2 + r.delay);
		@(posedge clk);
		issue <= 1'b1;
		issue_packet <= pkt;
		@(posedge clk);
		issue <= 1'b0;
	endtask

	// results are stable around the falling edge
	always @(negedge clk) begin
		if (full) saw_full = 1'b1;
		if (arst_n && result_valid) begin
			if (!pending[result.rob_tag]) begin
				$display("result arrived for tag %0d which has no branch in flight", result.rob_tag);
				errors++;
			end else begin
				if (result.next_instruction !== exp_next[result.rob_tag] ||
						result.redirect_mispredicted !== exp_mis[result.rob_tag]) begin
					$display("mismatch at %0t: tag %0d got %h/%b expected %h/%b", $time,
						result.rob_tag, result.next_instruction, result.redirect_mispredicted,
						exp_next[result.rob_tag], exp_mis[result.rob_tag]);
					errors++;
				end
				$display("test tag %0d done, next %h mispredict %b", result.rob_tag,
					result.next_instruction, result.redirect_mispredicted);
				pending[result.rob_tag] = 1'b0;
				outstanding--;
				checked++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 8);
		$display("watchdog expired with %0d branches still outstanding", outstanding);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		flush = 1'b0;
		issue = 1'b0;
		issue_packet = '0;
		cdb = '0;
		for (int i = 0; i < 4096; i++) slot_v[i] = 1'b0;
		for (int i = 0; i < 16; i++) pending[i] = 1'b0;
		// kind, funct3, v1, v2, pc, imm, pred, late, delay
		rows[0]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BEQ, 5, 5, 32'h100, 32'h40, 32'h140, 0, 0};
		rows[1]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BNE, 5, 5, 32'h200, 32'h40, 32'h240, 0, 0};
		rows[2]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BLT, 32'h80000000, 1, 32'h300,
			32'hfffffff0, 32'h2f0, 1, 0};	// cdb on issue edge
		rows[3]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BGE, 32'h80000000, 1, 32'h400,
			32'h20, 32'h404, 2, 8};
		rows[4]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BLTU, 32'h80000000, 1, 32'h500,
			32'h20, 32'h520, 3, 9};
		rows[5]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BGEU, 32'h80000000, 1, 32'h600,
			32'h80, 32'h680, 1, 10};
		rows[6]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BLTU, 1, 32'hffffffff, 32'h700,
			32'h10, 32'h704, 3, 6};
		rows[7]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BGE, 32'hffffffff, 32'hffffffff,
			32'h800, 32'h8, 32'h808, 0, 0};
		rows[8]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BEQ, 1, 2, 32'h900, 32'h8, 32'h904, 0, 0};
		rows[9]  = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BNE, 1, 2, 32'ha00, 32'hc, 32'ha04, 2, 1};
		rows[10] = '{rv_isa_pkg::KIND_JALR, rv_isa_pkg::BEQ, 32'h1000, 7, 32'hb00, 0, 32'h1007, 0, 0};
		rows[11] = '{rv_isa_pkg::KIND_JALR, rv_isa_pkg::BEQ, 32'h2000, 32'hfffffff0, 32'hc00, 0,
			0, 1, 4};
		rows[12] = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BLT, 1, 32'h80000000, 32'hd00,
			32'h40, 32'hd40, 0, 0};	// signed not taken
		rows[13] = '{rv_isa_pkg::KIND_BRANCH, rv_isa_pkg::BGEU, 1, 32'h80000000, 32'he00,
			32'h40, 32'he04, 0, 0};	// unsigned not taken
		for (int i = 14; i < N_ROWS; i++) begin
			rows[i] = '{rv_isa_pkg::KIND_BRANCH, f3_list[$unsigned($random(seed)) % 6],
				$random(seed), $random(seed), $random(seed) & 32'hfffffffc,
				$random(seed) & 32'h00000ffc, 0, 0, 0};
			rows[i].pred = rows[i].v1[0] ? rows[i].pc + 32'd4 : rows[i].pc + rows[i].imm;
		end
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < N_ROWS; i++) issue_row(i, rows[i], 1'b1);
		while (outstanding != 0) @(negedge clk);
		// flush phase, station filled with entries that never get operands
		for (int i = 0; i < `BRS_DEPTH; i++) issue_row(i, rows[4], 1'b0);
		repeat (3) @(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < `BRS_DEPTH; i++) pending[i] = 1'b0;
		outstanding = outstanding - `BRS_DEPTH;
		if (full !== 1'b0) begin
			$display("full stayed high after flush");
			errors++;
		end
		issue_row(`BRS_DEPTH, rows[0], 1'b1);
		issue_row(`BRS_DEPTH + 1, rows[10], 1'b1);
		for (int i = 0; i < 100 && outstanding != 0; i++) @(negedge clk);
		for (int t = 0; t < 16; t++) begin
			if (pending[t]) begin
				$display("no result arrived for tag %0d", t);
				errors++;
			end
		end
		if (!saw_full) begin
			$display("station never reported full while operands were pending");
			errors++;
		end
		$display("%0d results checked, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+.
rv_isa_pkg.sv
tomasulo_pkg.sv
branch_functional_unit.sv
branch_reservation_station.sv
branch_unit_top.sv
branch_unit_props.sv
branch_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       := branch_unit_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
